// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_pov_top
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

// File: col_calc.sv
module col_calc (
    input  pov_geom_pkg::theta_t                 dtheta,
    output logic [pov_geom_pkg::SCAN_RATE-1:0]   mask
);
    import pov_geom_pkg::*;

    // scanline refresh mask
    // a pair whose low index bits line up with the angle step
    // would just repeat what the previous step drew, so skip it
    // and spend the shift time on the other three quarters

    always_comb begin
        logic [1:0] lo; // low index bits of pair i
        for (int i = 0; i < SCAN_RATE; i++) begin
            lo = 2'(i);
            mask[i] = (lo != dtheta[1:0]); // set = refresh this pair
        end
    end

endmodule

// File: cube_gen.sv
module cube_gen (
    input  pov_geom_pkg::theta_t        dtheta,
    input  pov_geom_pkg::col_idx_t      index,
    output pov_geom_pkg::column_t [1:0] pair
);
    import pov_geom_pkg::*;

    logic [$clog2(NUM_COLS)-1:0] col_num [2];

    assign col_num[0] = {1'b0, index};
    assign col_num[1] = {1'b1, index}; // far side of the rotor

    // wire frame box, rows 2..13 by columns 8..24
    always_comb begin
        col_idx_t cc;      // folded column
        logic     in_box;  // inside the bounding box
        logic     on_edge; // on one of the four sides
        for (int k = 0; k < 2; k++) begin
            cc = col_idx_t'(col_num[k]);
            for (int r = 0; r < NUM_ROWS; r++) begin
                in_box  = (r >= 2) && (r <= 13) && (cc >= 8) && (cc <= 24);
                on_edge = (r == 2) || (r == 13) || (cc == 8) || (cc == 24);
                if (in_box && on_edge) begin
                    pair[k][r].red   = dtheta[6:4]; // faster colour cycling than sphere
                    pair[k][r].green = 3'd0;
                    pair[k][r].blue  = 3'd7;
                end else begin
                    pair[k][r] = '0; // hollow inside, dark outside
                end
            end
        end
    end

endmodule

// File: frame_manager.sv
module frame_manager (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    req,
    input  pov_ctrl_pkg::mode_t     mode,
    input  pov_geom_pkg::theta_t    dtheta,
    output logic                    ans_valid,
    output pov_ctrl_pkg::col_pair_t ans
);
    import pov_geom_pkg::*;
    import pov_ctrl_pkg::*;

    col_idx_t             pair_cnt;    // next pair in the sweep
    theta_t               last_theta;  // angle at previous req
    col_idx_t             cur_idx;     // pair answered for this req
    logic [SCAN_RATE-1:0] mask;        // refresh mask for current angle
    column_t [1:0]        sphere_pair;
    column_t [1:0]        cube_pair;
    col_pair_t            next_ans;    // answer being built

    // new angle means a new sweep from pair 0
    assign cur_idx = (dtheta != last_theta) ? '0 : pair_cnt;

    col_calc col_calc_i (
        .dtheta (dtheta),
        .mask   (mask)
    );

    sphere_gen sphere_gen_i (
        .dtheta (dtheta),
        .index  (cur_idx),
        .pair   (sphere_pair)
    );

    cube_gen cube_gen_i (
        .dtheta (dtheta),
        .index  (cur_idx),
        .pair   (cube_pair)
    );

    // pick the image source
    always_comb begin
        next_ans.index = cur_idx;
        next_ans.skip  = ~mask[cur_idx]; // masked pairs go out as skip
        next_ans.col_a = '0;
        next_ans.col_b = '0;
        case (mode)
            MODE_CYLINDER: begin
                // same colour all round, only row dependent
                for (int r = 0; r < NUM_ROWS; r++) begin
                    next_ans.col_a[r].red   = 3'(r >> 1);
                    next_ans.col_a[r].green = dtheta[7:5];
                    next_ans.col_a[r].blue  = 3'd1;
                end
                next_ans.col_b = next_ans.col_a; // both sides identical
            end
            MODE_SPHERE: begin
                next_ans.col_a = sphere_pair[0];
                next_ans.col_b = sphere_pair[1];
            end
            MODE_CUBE: begin
                next_ans.col_a = cube_pair[0];
                next_ans.col_b = cube_pair[1];
            end
            MODE_OFF: begin
                next_ans.col_a = '0; // blank panel
                next_ans.col_b = '0;
            end
            default: begin
                next_ans.col_a = '0;
                next_ans.col_b = '0;
            end
        endcase
    end

    // sweep bookkeeping
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ans_valid  <= 1'b0;
            pair_cnt   <= '0;
            last_theta <= '0;
        end else begin
            ans_valid <= req; // answer exactly one cycle after req
            if (req) begin
                pair_cnt   <= col_idx_t'(cur_idx + 1'b1); // wraps at 32
                last_theta <= dtheta;
            end
        end
    end

    // answer payload
    always_ff @(posedge clk_in) begin
        if (req) begin
            ans <= next_ans;
        end
    end

endmodule

// File: hub75_scan.sv
module hub75_scan (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    hold,
    input  logic                    ans_valid,
    input  pov_ctrl_pkg::col_pair_t ans,
    output logic                    req,
    output pov_geom_pkg::panel_t    panel
);
    import pov_geom_pkg::*;
    import pov_ctrl_pkg::*;

    scan_state_t                 state;
    col_pair_t                   pair_q; // pair being shown
    logic [$clog2(NUM_ROWS)-1:0] row;    // next row to shift

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= S_REQ;
            req   <= 1'b0;
            row   <= '0;
        end else begin
            req <= 1'b0; // single cycle pulse unless set below
            case (state)
                S_REQ: begin
                    req   <= 1'b1; // first pair after reset
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (ans_valid) begin
                        if (ans.skip) begin
                            req <= 1'b1; // masked pair, ask for the next one
                        end else begin
                            row   <= '0;
                            state <= S_SHIFT;
                        end
                    end
                end
                S_SHIFT: begin
                    // hold freezes the row pointer
                    if (!hold) begin
                        if (row == NUM_ROWS - 1) begin
                            state <= S_LATCH;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end
                end
                S_LATCH: begin
                    req   <= 1'b1; // next pair right after the strobe
                    state <= S_WAIT;
                end
                default: begin
                    state <= S_REQ;
                end
            endcase
        end
    end

    // take the pair only when it is going to be shown
    always_ff @(posedge clk_in) begin
        if (state == S_WAIT && ans_valid && !ans.skip) begin
            pair_q <= ans;
        end
    end

    // panel pins
    always_comb begin
        panel.pix_top  = pair_q.col_a[row];
        panel.pix_bot  = pair_q.col_b[row];
        panel.shift_en = (state == S_SHIFT) && !hold; // back-pressure
        panel.latch    = (state == S_LATCH);
        panel.addr     = pair_q.index;
    end

endmodule

// File: pov_ctrl_pkg.sv
package pov_ctrl_pkg;

    // image source select
    typedef enum logic [1:0] {
        MODE_CYLINDER = 2'd0,
        MODE_SPHERE   = 2'd1,
        MODE_CUBE     = 2'd2,
        MODE_OFF      = 2'd3
    } mode_t;

    // driver fsm
    typedef enum logic [1:0] {
        S_REQ,   // first request out of reset
        S_WAIT,  // waiting on the answer
        S_SHIFT, // rows going out
        S_LATCH  // address strobe
    } scan_state_t;

    // answer from frame manager to driver
    typedef struct packed {
        pov_geom_pkg::column_t  col_a; // column c
        pov_geom_pkg::column_t  col_b; // column c+32
        pov_geom_pkg::col_idx_t index; // pair number
        logic                   skip;  // masked off, columns meaningless
    } col_pair_t;

endpackage

// File: pov_geom_pkg.sv
package pov_geom_pkg;

    // panel and rotor geometry
    localparam int NUM_ROWS  = 16;           // leds per column
    localparam int NUM_COLS  = 64;           // columns per revolution slice
    localparam int SCAN_RATE = NUM_COLS / 2; // pairs per sweep, c and c+32
    localparam int ROT_RES   = 256;          // angle steps per turn

    typedef logic [$clog2(ROT_RES)-1:0]   theta_t;   // rotor angle step
    typedef logic [$clog2(SCAN_RATE)-1:0] col_idx_t; // pair index 0..31

    // 3/3/3 colour, red on top bits
    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [2:0] blue;
    } pixel_t;

    // one full column, row 0 in the low bits
    typedef pixel_t [NUM_ROWS-1:0] column_t;

    // what goes out to the panel pins each cycle
    typedef struct packed {
        pixel_t   pix_top;  // pixel of column c
        pixel_t   pix_bot;  // pixel of column c+32
        logic     shift_en; // row valid this cycle
        logic     latch;    // column done, addr valid
        col_idx_t addr;     // pair being latched
    } panel_t;

endpackage

// File: pov_top.sv
module pov_top (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 hold,
    input  pov_ctrl_pkg::mode_t  mode,
    input  pov_geom_pkg::theta_t dtheta,
    output pov_geom_pkg::panel_t panel
);
    import pov_ctrl_pkg::*;

    logic      req;       // driver asks for a pair
    logic      ans_valid; // pair ready
    col_pair_t ans;

    // image side, picks and masks column pairs
    frame_manager frame_manager_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req       (req),
        .mode      (mode),
        .dtheta    (dtheta),
        .ans_valid (ans_valid),
        .ans       (ans)
    );

    // panel side, shifts and latches
    hub75_scan hub75_scan_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .hold      (hold),
        .ans_valid (ans_valid),
        .ans       (ans),
        .req       (req),
        .panel     (panel)
    );

endmodule

// File: sources.f
pov_geom_pkg.sv
pov_ctrl_pkg.sv
col_calc.sv
sphere_gen.sv
cube_gen.sv
frame_manager.sv
hub75_scan.sv
pov_top.sv
tb_pov_top.sv

// File: sphere_gen.sv
module sphere_gen (
    input  pov_geom_pkg::theta_t        dtheta,
    input  pov_geom_pkg::col_idx_t      index,
    output pov_geom_pkg::column_t [1:0] pair
);
    import pov_geom_pkg::*;

    // full 0..63 column number for both halves of the pair
    logic [$clog2(NUM_COLS)-1:0] col_num [2];

    assign col_num[0] = {1'b0, index}; // column c
    assign col_num[1] = {1'b1, index}; // column c+32, opposite side

    // disc of radius rows/2 centred on the panel, evaluated per pixel
    always_comb begin
        int       dr;  // row offset from centre
        int       dc;  // column offset from centre
        col_idx_t cc;  // column folded into the sweep
        for (int k = 0; k < 2; k++) begin
            cc = col_idx_t'(col_num[k]);          // mod 32
            dc = int'(cc) - SCAN_RATE / 2;
            for (int r = 0; r < NUM_ROWS; r++) begin
                dr = r - NUM_ROWS / 2;
                if (dr * dr + dc * dc < (NUM_ROWS / 2) * (NUM_ROWS / 2)) begin
                    pair[k][r].red   = dtheta[7:5];   // tint rotates with angle
                    pair[k][r].green = 3'd7;
                    pair[k][r].blue  = 3'(r >> 1);    // vertical gradient
                end else begin
                    pair[k][r] = '0;                  // outside the sphere
                end
            end
        end
    end

endmodule

// File: tb_pov_top.sv
module tb_pov_top;
    import pov_geom_pkg::*;
    import pov_ctrl_pkg::*;

    localparam int CAPTURE_LIMIT = 200; // cycles allowed from start of a capture to latch
    localparam int SWEEP_PAIRS   = 24;  // refreshed pairs per sweep, 3 of every 4

    logic   clk_in;
    logic   rst_in;
    logic   hold      = 1'b0;
    logic   hold_rand = 1'b0; // random back-pressure on/off
    mode_t  mode;
    theta_t dtheta;
    panel_t panel;

    mode_t  cur_mode;   // shadow of what was last driven
    theta_t cur_theta;
    int     model_cnt;  // model of the pair counter
    theta_t model_last; // model of the angle seen at the previous req
    int     checks;
    int     errors;
    logic   timed_out;  // a capture never saw its latch

    pov_top pov_top_i (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .hold   (hold),
        .mode   (mode),
        .dtheta (dtheta),
        .panel  (panel)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    // hold toggles randomly only while enabled
    always @(posedge clk_in) begin
        hold <= hold_rand && ($urandom_range(2) == 0);
    end

    // refresh mask, set when low index bits differ from the angle's
    function automatic logic mask_bit(input theta_t th, input int i);
        logic [1:0] lo;
        lo = 2'(i);
        return lo != th[1:0];
    endfunction

    function automatic col_idx_t first_refreshed(input theta_t th);
        int i;
        i = 0;
        while (!mask_bit(th, i)) begin
            i++;
        end
        return col_idx_t'(i);
    endfunction

    // image rules per mode, cc already folded mod 32
    function automatic pixel_t expected_pixel(input mode_t m, input theta_t th,
                                              input int cc, input int r);
        pixel_t p;
        int     dr;
        int     dc;
        p  = '0;
        dr = r - 8;
        dc = cc - 16;
        case (m)
            MODE_CYLINDER: begin
                p.red   = 3'(r / 2); // r[3:1]
                p.green = th[7:5];
                p.blue  = 3'd1;
            end
            MODE_SPHERE: begin
                if (dr * dr + dc * dc < 64) begin
                    p.red   = th[7:5];
                    p.green = 3'd7;
                    p.blue  = 3'(r / 2);
                end
            end
            MODE_CUBE: begin
                if (r >= 2 && r <= 13 && cc >= 8 && cc <= 24 &&
                    (r == 2 || r == 13 || cc == 8 || cc == 24)) begin
                    p.red  = th[6:4];
                    p.blue = 3'd7;
                end
            end
            default: p = '0; // off
        endcase
        return p;
    endfunction

    // next refreshed pair index, skipping masked ones like the answer rule
    function automatic col_idx_t advance_sweep();
        col_idx_t idx;
        if (cur_theta != model_last) begin
            model_cnt = 0; // new angle, new sweep
        end
        model_last = cur_theta;
        while (!mask_bit(cur_theta, model_cnt)) begin
            model_cnt = (model_cnt + 1) % SCAN_RATE;
        end
        idx       = col_idx_t'(model_cnt);
        model_cnt = (model_cnt + 1) % SCAN_RATE;
        return idx;
    endfunction

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error in %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input col_idx_t exp, input col_idx_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error in %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_column(input string name, input column_t exp, input column_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error in %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic expect_idle(input string when);
        if (panel.shift_en !== 1'b0 || panel.latch !== 1'b0) begin
            errors++;
            $display("%s: shift_en or latch is not low", when);
        end
    endtask

    // only called right after a latch, so the next req sees the new values
    task automatic apply_inputs(input mode_t m, input theta_t th);
        @(posedge clk_in);
        mode      <= m;
        dtheta    <= th;
        cur_mode  = m;
        cur_theta = th;
    endtask

    // follow one refreshed pair from answer to latch, sampled at negedge
    task automatic capture_pair(input string name, output col_idx_t got_idx);
        col_idx_t exp_idx;
        column_t  exp_a;
        column_t  exp_b;
        column_t  got_a;
        column_t  got_b;
        int       rows;
        int       waited;
        logic     done;
        got_idx = '0;
        if (timed_out) begin
            return; // an earlier capture already lost the DUT
        end
        exp_idx = advance_sweep();
        for (int r = 0; r < NUM_ROWS; r++) begin
            exp_a[r] = expected_pixel(cur_mode, cur_theta, int'(exp_idx), r);
            exp_b[r] = exp_a[r]; // c+32 folds to the same cc
        end
        got_a  = '0;
        got_b  = '0;
        rows   = 0;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < CAPTURE_LIMIT) begin
            @(negedge clk_in);
            waited++;
            if (hold && panel.shift_en) begin
                errors++;
                $display("%s: shift_en high while hold is high", name);
            end
            if (panel.shift_en) begin
                if (rows < NUM_ROWS) begin
                    check_pixel(name, exp_a[rows], panel.pix_top);
                    check_pixel(name, exp_b[rows], panel.pix_bot);
                    got_a[rows] = panel.pix_top;
                    got_b[rows] = panel.pix_bot;
                end
                rows++;
            end
            done = panel.latch;
        end
        if (!done) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout in %s: no latch after %0d cycles", name, CAPTURE_LIMIT);
        end else begin
            got_idx = panel.addr;
            if (rows != NUM_ROWS) begin
                errors++;
                $display("%s: %0d rows shifted before latch instead of 16", name, rows);
            end
            if (!mask_bit(cur_theta, int'(panel.addr))) begin
                errors++;
                $display("%s: masked-off pair %0d was latched", name, panel.addr);
            end
            check_addr(name, exp_idx, panel.addr);
            check_column(name, exp_a, got_a);
            check_column(name, exp_b, got_b);
        end
    endtask

    task automatic capture_sweep(input string name, input int pairs);
        col_idx_t idx;
        for (int n = 0; n < pairs && !timed_out; n++) begin
            capture_pair(name, idx);
        end
    endtask

    task automatic reset_quiet();
        @(posedge clk_in); // first reset edge
        @(negedge clk_in);
        expect_idle("during reset");
        @(posedge clk_in); // second reset edge
        rst_in <= 1'b0;
        @(negedge clk_in);
        expect_idle("first cycle after reset");
        @(posedge clk_in);
        @(negedge clk_in);
        expect_idle("cycle of the first req");
    endtask

    // runs on the sphere inputs given at reset
    task automatic sweep_sphere();
        capture_sweep("sphere sweep", SWEEP_PAIRS);
    endtask

    task automatic sweep_other_modes();
        apply_inputs(MODE_CUBE, 8'h13);
        capture_sweep("cube 13", SWEEP_PAIRS);
        apply_inputs(MODE_CUBE, 8'hc6);
        capture_sweep("cube c6", SWEEP_PAIRS);
        apply_inputs(MODE_CYLINDER, 8'h13);
        capture_sweep("cylinder 13", SWEEP_PAIRS);
        apply_inputs(MODE_CYLINDER, 8'hc6);
        capture_sweep("cylinder c6", SWEEP_PAIRS);
        apply_inputs(MODE_OFF, 8'h13);
        capture_sweep("off 13", SWEEP_PAIRS);
        apply_inputs(MODE_OFF, 8'hc6);
        capture_sweep("off c6", SWEEP_PAIRS);
    endtask

    task automatic change_angle_mid_sweep();
        col_idx_t idx;
        apply_inputs(MODE_SPHERE, 8'h41);
        capture_sweep("angle change before", 5);
        apply_inputs(MODE_SPHERE, 8'hb4); // low bits 0, so pair 0 is skipped
        capture_pair("angle change after", idx);
        if (!timed_out) begin
            check_addr("angle change restart", first_refreshed(8'hb4), idx);
        end
    endtask

    task automatic shift_under_hold();
        hold_rand = 1'b1; // set at negedge, no posedge race
        apply_inputs(MODE_CUBE, 8'h77);
        capture_sweep("back-pressure", SWEEP_PAIRS);
        hold_rand = 1'b0;
    endtask

    task automatic cover_all_masks();
        for (int d = 0; d < 4; d++) begin
            apply_inputs(MODE_CYLINDER, {6'h1b, 2'(d)});
            capture_sweep("mask coverage", SWEEP_PAIRS);
        end
    endtask

    initial begin
        void'($urandom(32'h716cfa88));
        rst_in     = 1'b1;
        mode       = MODE_SPHERE; // first req right after reset uses these
        dtheta     = 8'h5a;
        cur_mode   = MODE_SPHERE;
        cur_theta  = 8'h5a;
        model_cnt  = 0;
        model_last = '0;
        checks     = 0;
        errors     = 0;
        timed_out  = 1'b0;
        reset_quiet();
        sweep_sphere();
        sweep_other_modes();
        change_angle_mid_sweep();
        shift_under_hold();
        cover_all_masks();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
